//--- source/spi_consts.svh
// SPI master constants
// Register map, bus widths, version word, FIFO depth, gap length and pin counts
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

`define SPI_SLAVES      2
`define SPI_PINS        8
`define SPI_FIFO_DEPTH  4
`define SPI_GAP_CYCLES  6           // Idle clk cycles between bytes

`define SPI_APB_AW      8
`define SPI_APB_DW      32

`define SPI_VERSION     32'h0001_0200

// Word offsets
`define SPI_REG_CFG     8'h00
`define SPI_REG_GPIO    8'h04
`define SPI_REG_VERSION 8'h08
`define SPI_REG_TX      8'h0C
`define SPI_REG_RX      8'h10
`define SPI_REG_STATUS  8'h14

`endif

//--- source/spi_pkg.sv
// SPI master types
// Clock divider type, engine states, CFG mode fields and CFG word union
`include "spi_consts.svh"

package spi_pkg;

  typedef logic [3:0] spi_clk_div_t;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    GAP
  } spi_state_e;

  // Field layout of the CFG word, LSB first: clk_div, cpol, cpha, cs_sel
  typedef struct packed {
    logic [`SPI_APB_DW-`SPI_SLAVES-7:0] rsvd;
    logic [`SPI_SLAVES-1:0]             cs_sel;
    logic                               cpha;
    logic                               cpol;
    spi_clk_div_t                       clk_div;   // Half period is clk_div+1 cycles
  } spi_mode_t;

  // Bus side sees the raw word, SPI side the fields
  typedef union packed {
    logic [`SPI_APB_DW-1:0] raw;
    spi_mode_t              mode;
  } spi_cfg_word_u;

endpackage

//--- source/spi_byte_fifo.sv
// Single clock byte FIFO with full and empty flags
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_byte_fifo #(
  parameter int DEPTH = `SPI_FIFO_DEPTH
) (
  input  logic       clk,
  input  logic       arst,
  input  logic       push_i,
  input  logic [7:0] data_i,
  input  logic       pop_i,
  output logic [7:0] data_o,
  output logic       full_o,
  output logic       empty_o
);
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [7:0]    mem [DEPTH];
  logic [PW-1:0] wptr_q;
  logic [PW-1:0] rptr_q;
  logic [CW-1:0] count_q;
  logic          do_push;
  logic          do_pop;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CW'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;   // Overflow dropped
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem[rptr_q];         // Head byte

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) wptr_q <= next_ptr(wptr_q);
      if (do_pop) rptr_q <= next_ptr(rptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wptr_q] <= data_i;
  end

endmodule

//--- source/spi_sck_gen.sv
// SCK half period tick generator
`timescale 1ns/1ps

module spi_sck_gen import spi_pkg::*; (
  input  logic         clk,
  input  logic         arst,
  input  logic         en_i,
  input  spi_clk_div_t clk_div_i,
  output logic         half_tick_o
);
  spi_clk_div_t cnt_q;

  // One tick every clk_div_i+1 cycles while enabled
  assign half_tick_o = en_i && (cnt_q == clk_div_i);

  // Held at zero while disabled, so every enable starts a fresh half period
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      cnt_q <= '0;
    end else if (!en_i || half_tick_o) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

//--- source/spi_shift_engine.sv
// SPI byte transfer engine
// Pops TX bytes, shifts them out MSB first in any CPOL/CPHA mode, pushes RX bytes
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_shift_engine import spi_pkg::*; (
  input  logic       clk,
  input  logic       arst,
  input  logic       cpol_i,
  input  logic       cpha_i,
  input  logic       half_tick_i,
  input  logic       tx_empty_i,
  input  logic [7:0] tx_data_i,
  output logic       tx_pop_o,
  input  logic       rx_full_i,
  output logic       rx_push_o,
  output logic [7:0] rx_data_o,
  output logic       sck_en_o,
  output logic       sck_o,
  output logic       mosi_o,
  input  logic       miso_i,
  output logic       busy_o
);
  localparam int GAP_W = (`SPI_GAP_CYCLES > 1) ? $clog2(`SPI_GAP_CYCLES) : 1;

  spi_state_e       state_q;
  spi_state_e       state_d;
  logic [3:0]       half_cnt_q;
  logic             phase_q;
  logic [GAP_W-1:0] gap_cnt_q;
  logic             mosi_q;
  logic             rx_push_q;
  logic [7:0]       tx_sh_q;
  logic [7:0]       rx_sh_q;
  logic             tick;
  logic             can_start;
  logic             gap_done;
  logic             last_half;
  logic             sample_edge;
  logic             shift_edge;

  assign tick      = half_tick_i && (state_q == SHIFT);
  assign can_start = !tx_empty_i && !rx_full_i;   // Full RX holds the engine
  assign gap_done  = (state_q == GAP) && (gap_cnt_q == GAP_W'(`SPI_GAP_CYCLES - 1));
  assign tx_pop_o  = can_start && ((state_q == IDLE) || gap_done);
  assign last_half = tick && (half_cnt_q == 4'd15);

  // Even half ticks are leading edges
  assign sample_edge = tick && (half_cnt_q[0] == cpha_i);
  assign shift_edge  = tick && (half_cnt_q[0] != cpha_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (tx_pop_o) state_d = SHIFT;
      SHIFT:   if (last_half) state_d = GAP;
      GAP: begin
        if (gap_done) state_d = tx_pop_o ? SHIFT : IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state_q    <= IDLE;
      half_cnt_q <= '0;
      phase_q    <= 1'b0;
      gap_cnt_q  <= '0;
      mosi_q     <= 1'b0;
      rx_push_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      rx_push_q <= last_half;              // Byte complete one cycle after last edge
      if (tx_pop_o) begin
        half_cnt_q <= '0;
        phase_q    <= 1'b0;
        if (!cpha_i) mosi_q <= tx_data_i[7];   // CPHA 0 drives bit 7 up front
      end else if (tick) begin
        half_cnt_q <= half_cnt_q + 1'b1;
        phase_q    <= ~phase_q;
      end
      if (shift_edge) mosi_q <= tx_sh_q[7];
      if (state_q == SHIFT) begin
        gap_cnt_q <= '0;
      end else if ((state_q == GAP) && !gap_done) begin
        gap_cnt_q <= gap_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_pop_o) begin
      tx_sh_q <= cpha_i ? tx_data_i : {tx_data_i[6:0], 1'b0};
    end else if (shift_edge) begin
      tx_sh_q <= {tx_sh_q[6:0], 1'b0};
    end
    if (sample_edge) rx_sh_q <= {rx_sh_q[6:0], miso_i};
  end

  assign sck_o     = cpol_i ^ phase_q;    // Rests at cpol when idle
  assign sck_en_o  = (state_q == SHIFT);
  assign mosi_o    = mosi_q;
  assign rx_push_o = rx_push_q;
  assign rx_data_o = rx_sh_q;
  assign busy_o    = (state_q != IDLE);

endmodule

//--- source/apb_spi_regs.sv
// APB register block of the SPI master
// CFG and GPIO storage, access checks, read mux and FIFO strobes
`timescale 1ns/1ps
`include "spi_consts.svh"

module apb_spi_regs import spi_pkg::*; (
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`SPI_APB_AW-1:0] paddr_i,
  input  logic [`SPI_APB_DW-1:0] pwdata_i,
  output logic [`SPI_APB_DW-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  input  logic                   tx_full_i,
  output logic                   tx_push_o,
  output logic [7:0]             tx_data_o,
  input  logic                   rx_empty_i,
  input  logic [7:0]             rx_data_i,
  output logic                   rx_pop_o,
  input  logic                   busy_i,
  output spi_mode_t              cfg_mode_o,
  output logic [`SPI_PINS-1:0]   gpio_o
);
  // cpol 0, cpha 0, no slave selected, divider 9
  localparam spi_mode_t CFG_RST = '{
    rsvd:    '0,
    cs_sel:  '0,
    cpha:    1'b0,
    cpol:    1'b0,
    clk_div: 4'd9
  };

  spi_cfg_word_u        cfg_q;
  spi_cfg_word_u        cfg_d;
  logic [`SPI_PINS-1:0] gpio_q;
  logic                 hit_cfg;
  logic                 hit_gpio;
  logic                 hit_ver;
  logic                 hit_tx;
  logic                 hit_rx;
  logic                 hit_stat;
  logic                 access;
  logic                 wr_ok;
  logic                 rd_ok;
  logic                 err;
  logic                 xfer;
  logic                 wr_en;
  logic                 rd_en;

  assign hit_cfg  = (paddr_i == `SPI_REG_CFG);
  assign hit_gpio = (paddr_i == `SPI_REG_GPIO);
  assign hit_ver  = (paddr_i == `SPI_REG_VERSION);
  assign hit_tx   = (paddr_i == `SPI_REG_TX);
  assign hit_rx   = (paddr_i == `SPI_REG_RX);
  assign hit_stat = (paddr_i == `SPI_REG_STATUS);

  assign access = psel_i && penable_i;
  assign wr_ok  = hit_cfg || hit_gpio || hit_tx;
  assign rd_ok  = hit_cfg || hit_gpio || hit_ver || hit_rx || hit_stat;
  assign err    = pwrite_i ? !wr_ok : !rd_ok;

  // Stall a TX write until the FIFO has a free slot
  assign pready_o  = !(access && pwrite_i && hit_tx && tx_full_i);
  assign pslverr_o = access && err;

  assign xfer  = access && pready_o && !err;
  assign wr_en = xfer && pwrite_i;
  assign rd_en = xfer && !pwrite_i;

  assign tx_push_o = wr_en && hit_tx;
  assign tx_data_o = pwdata_i[7:0];
  assign rx_pop_o  = rd_en && hit_rx && !rx_empty_i;

  always_comb begin
    cfg_d = cfg_q;
    if (wr_en && hit_cfg) begin
      cfg_d.raw             = pwdata_i;
      cfg_d.mode.clk_div[0] = 1'b1;   // Divider always odd
    end
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      cfg_q.mode <= CFG_RST;
      gpio_q     <= '0;
    end else begin
      cfg_q <= cfg_d;
      if (wr_en && hit_gpio) gpio_q <= pwdata_i[`SPI_PINS-1:0];
    end
  end

  always_comb begin
    prdata_o = '0;
    if (rd_en) begin
      case (paddr_i)
        `SPI_REG_CFG:     prdata_o = cfg_q.raw;
        `SPI_REG_GPIO:    prdata_o = `SPI_APB_DW'(gpio_q);
        `SPI_REG_VERSION: prdata_o = `SPI_VERSION;
        `SPI_REG_RX:      prdata_o = rx_empty_i ? '0 : `SPI_APB_DW'(rx_data_i);
        `SPI_REG_STATUS:  prdata_o = `SPI_APB_DW'({busy_i, rx_empty_i, tx_full_i});
        default:          prdata_o = '0;
      endcase
    end
  end

  assign cfg_mode_o = cfg_q.mode;
  assign gpio_o     = gpio_q;

endmodule

//--- source/apb_spi_master.sv
// SPI master with APB register interface
// Registers, TX and RX FIFOs, sck tick generator and shift engine
`timescale 1ns/1ps
`include "spi_consts.svh"

module apb_spi_master import spi_pkg::*; (
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`SPI_APB_AW-1:0] paddr_i,
  input  logic [`SPI_APB_DW-1:0] pwdata_i,
  output logic [`SPI_APB_DW-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  output logic                   sck_o,
  output logic                   mosi_o,
  input  logic                   miso_i,
  output logic [`SPI_SLAVES-1:0] cs_n_o,
  output logic [`SPI_PINS-1:0]   gpio_o
);
  spi_mode_t  cfg_mode;
  logic       tx_push;
  logic [7:0] tx_wdata;
  logic       tx_pop;
  logic [7:0] tx_rdata;
  logic       tx_full;
  logic       tx_empty;
  logic       rx_push;
  logic [7:0] rx_wdata;
  logic       rx_pop;
  logic [7:0] rx_rdata;
  logic       rx_full;
  logic       rx_empty;
  logic       busy;
  logic       sck_en;
  logic       half_tick;

  apb_spi_regs u_regs (
    .clk        (clk),
    .arst       (arst),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .tx_full_i  (tx_full),
    .tx_push_o  (tx_push),
    .tx_data_o  (tx_wdata),
    .rx_empty_i (rx_empty),
    .rx_data_i  (rx_rdata),
    .rx_pop_o   (rx_pop),
    .busy_i     (busy),
    .cfg_mode_o (cfg_mode),
    .gpio_o     (gpio_o)
  );

  spi_byte_fifo #(.DEPTH(`SPI_FIFO_DEPTH)) u_tx_fifo (
    .clk     (clk),
    .arst    (arst),
    .push_i  (tx_push),
    .data_i  (tx_wdata),
    .pop_i   (tx_pop),
    .data_o  (tx_rdata),
    .full_o  (tx_full),
    .empty_o (tx_empty)
  );

  spi_byte_fifo #(.DEPTH(`SPI_FIFO_DEPTH)) u_rx_fifo (
    .clk     (clk),
    .arst    (arst),
    .push_i  (rx_push),
    .data_i  (rx_wdata),
    .pop_i   (rx_pop),
    .data_o  (rx_rdata),
    .full_o  (rx_full),
    .empty_o (rx_empty)
  );

  spi_sck_gen u_sck_gen (
    .clk         (clk),
    .arst        (arst),
    .en_i        (sck_en),
    .clk_div_i   (cfg_mode.clk_div),
    .half_tick_o (half_tick)
  );

  spi_shift_engine u_engine (
    .clk         (clk),
    .arst        (arst),
    .cpol_i      (cfg_mode.cpol),
    .cpha_i      (cfg_mode.cpha),
    .half_tick_i (half_tick),
    .tx_empty_i  (tx_empty),
    .tx_data_i   (tx_rdata),
    .tx_pop_o    (tx_pop),
    .rx_full_i   (rx_full),
    .rx_push_o   (rx_push),
    .rx_data_o   (rx_wdata),
    .sck_en_o    (sck_en),
    .sck_o       (sck_o),
    .mosi_o      (mosi_o),
    .miso_i      (miso_i),
    .busy_o      (busy)
  );

  assign cs_n_o = ~cfg_mode.cs_sel;   // Active low selects

endmodule

//--- testbench/spi_echo_slave.sv
// Behavioral SPI slave model
// Sends back each received byte during the next byte, preloaded with A5
`timescale 1ns/1ps

module spi_echo_slave #(
  parameter logic [7:0] PRELOAD = 8'hA5
) (
  input  logic cpol_i,
  input  logic cpha_i,
  input  logic sck_i,
  input  logic mosi_i,
  input  logic cs_n_i,
  output logic miso_o
);
  logic [7:0] tx_q;
  logic [7:0] rx_q;
  logic       miso_q;
  int         bit_cnt;

  initial begin
    tx_q    = PRELOAD;
    rx_q    = 8'h00;
    miso_q  = 1'b0;
    bit_cnt = 0;
  end

  // CPHA 0 presents bit 7 before the first edge
  assign miso_o = cpha_i ? miso_q : tx_q[7];

  always @(sck_i) begin
    if (!cs_n_i) begin
      if (sck_i != cpol_i) begin   // Leading edge
        if (!cpha_i) begin
          rx_q = {rx_q[6:0], mosi_i};
        end else begin
          miso_q = tx_q[7];
          tx_q   = {tx_q[6:0], 1'b0};
        end
      end else begin
        if (cpha_i) rx_q = {rx_q[6:0], mosi_i};
        else tx_q = {tx_q[6:0], 1'b0};
        bit_cnt++;
        if (bit_cnt == 8) begin
          bit_cnt = 0;
          tx_q    = rx_q;          // Echo on next byte
        end
      end
    end
  end

endmodule

//--- testbench/tb_apb_spi_master.sv
// Testbench for the APB SPI master
// Clock, reset, APB tasks, echo checks, sck timing monitor and back-pressure test
`timescale 1ns/1ps
`include "spi_consts.svh"

module tb_apb_spi_master;
  localparam int TMO = 4000;

  logic                   clk;
  logic                   arst;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`SPI_APB_AW-1:0] paddr;
  logic [`SPI_APB_DW-1:0] pwdata;
  logic [`SPI_APB_DW-1:0] prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   sck;
  logic                   mosi;
  logic                   miso;
  logic [`SPI_SLAVES-1:0] cs_n;
  logic [`SPI_PINS-1:0]   gpio;
  logic                   slv_cpol;
  logic                   slv_cpha;
  logic [31:0]            cur_cfg;
  int                     cur_div;
  logic [7:0]             last_sent;
  logic [7:0]             exp_q[$];
  logic                   sck_prev;
  int                     toggles;
  int                     gap;

  apb_spi_master dut_i (
    .clk(clk), .arst(arst), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
    .pslverr_o(pslverr), .sck_o(sck), .mosi_o(mosi), .miso_i(miso), .cs_n_o(cs_n),
    .gpio_o(gpio)
  );

  spi_echo_slave u_slave (
    .cpol_i(slv_cpol), .cpha_i(slv_cpha), .sck_i(sck), .mosi_i(mosi),
    .cs_n_i(cs_n[0]), .miso_o(miso)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic die(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check(input logic ok, input string what, input logic [31:0] got,
                       input logic [31:0] exp);
    assert (ok) else begin
      $display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
      die("Check failed");
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err, output int stall);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    stall = 0;
    forever begin
      @(negedge clk);
      if (pready) break;
      stall++;
      if (stall > TMO) die("Timeout waiting for pready");
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    int          st;
    apb_xfer(1'b1, addr, data, rd, err, st);
    check(err === exp_err, "pslverr on write", {31'd0, err}, {31'd0, exp_err});
  endtask

  task automatic reg_read(input logic [7:0] addr, input logic exp_err, output logic [31:0] rd);
    logic err;
    int   st;
    apb_xfer(1'b0, addr, 32'd0, rd, err, st);
    check(err === exp_err, "pslverr on read", {31'd0, err}, {31'd0, exp_err});
  endtask

  task automatic expect_reg(input logic [7:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] rd;
    reg_read(addr, 1'b0, rd);
    check(rd === exp, what, rd, exp);
  endtask

  // Deselect, change mode, then select slave 0, so no stray sck edge reaches it
  task automatic set_mode(input int div, input logic cpol, input logic cpha);
    logic [31:0] w;
    reg_write(`SPI_REG_CFG, cur_cfg & ~32'hC0, 1'b0);
    w = {24'd0, 2'b00, cpha, cpol, 4'(div)};
    reg_write(`SPI_REG_CFG, w, 1'b0);
    cur_div  = (div | 1) + 1;
    slv_cpol = cpol;
    slv_cpha = cpha;
    w[6]     = 1'b1;
    reg_write(`SPI_REG_CFG, w, 1'b0);
    cur_cfg = w | 32'h1;
  endtask

  task automatic send_byte(input logic [7:0] b, output int stall);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, `SPI_REG_TX, {24'd0, b}, rd, err, stall);
    check(!err, "pslverr on TX write", {31'd0, err}, 32'd0);
    exp_q.push_back(last_sent);
    last_sent = b;
  endtask

  task automatic recv_check();
    logic [31:0] rd;
    logic [7:0]  exp;
    exp = exp_q.pop_front();
    reg_read(`SPI_REG_RX, 1'b0, rd);
    check(rd === {24'd0, exp}, "RX echo byte", rd, {24'd0, exp});
  endtask

  task automatic wait_idle();
    logic [31:0] rd;
    int          n;
    n = 0;
    do begin
      reg_read(`SPI_REG_STATUS, 1'b0, rd);
      n++;
      if (n > TMO) die("Timeout waiting for the engine to go idle");
    end while (rd[2]);
  endtask

  // Idle sck rests at cpol
  assert property (@(negedge clk) disable iff (arst)
                   (!dut_i.u_engine.busy_o) |-> (sck === slv_cpol))
    else begin
      $display("ERR %0t ns: idle sck level got %b expected %b", $time, sck, slv_cpol);
      die("Check failed");
    end

  // sck half period and toggle count monitor
  always @(negedge clk) begin
    if (!arst) begin
      gap++;
      if (dut_i.u_engine.busy_o) begin
        if (sck !== sck_prev) begin
          if (toggles != 0) check(gap == cur_div, "sck half period", gap, cur_div);
          toggles = (toggles == 15) ? 0 : toggles + 1;
          gap     = 0;
        end
      end else begin
        check(toggles == 0, "sck toggles per byte", toggles, 0);
      end
      sck_prev = sck;
    end
  end

  initial begin
    logic [31:0] rd;
    logic [7:0]  g;
    int          st;
    void'($urandom(14393));
    arst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    slv_cpol = 1'b0;
    slv_cpha = 1'b0;
    cur_cfg = 32'h9;
    cur_div = 10;
    last_sent = 8'hA5;
    sck_prev = 1'b0;
    toggles = 0;
    gap = 0;
    repeat (8) @(posedge clk);
    arst <= 1'b0;
    @(negedge clk);
    check(sck === 1'b0 && mosi === 1'b0, "sck and mosi after reset", {30'd0, sck, mosi},
          32'd0);
    check(cs_n === '1, "cs_n after reset", 32'(cs_n), 32'h3);
    check(pready === 1'b1 && pslverr === 1'b0, "APB outputs after reset",
          {30'd0, pready, pslverr}, 32'd2);
    expect_reg(`SPI_REG_VERSION, `SPI_VERSION, "VERSION");
    expect_reg(`SPI_REG_CFG, 32'h9, "CFG reset value");
    expect_reg(`SPI_REG_STATUS, 32'h2, "STATUS after reset");

    // Raw word read back, divider forced odd, cs_sel 2'b10
    reg_write(`SPI_REG_CFG, 32'hABCD_1284, 1'b0);
    expect_reg(`SPI_REG_CFG, 32'hABCD_1285, "CFG readback");
    check(cs_n === 2'b01, "cs_n from cs_sel", 32'(cs_n), 32'h1);
    g = 8'($urandom);
    reg_write(`SPI_REG_GPIO, {24'd0, g}, 1'b0);
    expect_reg(`SPI_REG_GPIO, {24'd0, g}, "GPIO readback");
    check(gpio === g, "gpio pins", 32'(gpio), {24'd0, g});
    reg_write(`SPI_REG_CFG, 32'h9, 1'b0);

    // Illegal accesses
    reg_write(8'h18, 32'hFFFF_FFFF, 1'b1);
    reg_read(8'h18, 1'b1, rd);
    reg_write(`SPI_REG_VERSION, 32'h0, 1'b1);
    reg_write(`SPI_REG_RX, 32'h55, 1'b1);
    reg_write(`SPI_REG_STATUS, 32'h7, 1'b1);
    reg_read(`SPI_REG_TX, 1'b1, rd);
    expect_reg(`SPI_REG_CFG, 32'h9, "CFG after illegal writes");
    expect_reg(`SPI_REG_GPIO, {24'd0, g}, "GPIO after illegal writes");
    expect_reg(`SPI_REG_STATUS, 32'h2, "STATUS after illegal writes");

    // All four modes
    for (int m = 0; m < 4; m++) begin
      set_mode(2 * m + 1, m[1], m[0]);
      for (int i = 0; i < 3; i++) send_byte(8'($urandom), st);
      wait_idle();
      for (int i = 0; i < 3; i++) recv_check();
    end

    // Back-pressure with the slowest sck
    set_mode(15, 1'b0, 1'b0);
    for (int i = 0; i < 6; i++) begin
      send_byte(8'($urandom), st);
      if (i == 5) check(st > 0, "TX write stalled on full FIFO", st, 1);
    end
    wait_idle();
    expect_reg(`SPI_REG_STATUS, 32'h0, "STATUS with RX full and engine held");
    for (int i = 0; i < 4; i++) recv_check();
    wait_idle();
    for (int i = 0; i < 2; i++) recv_check();
    expect_reg(`SPI_REG_RX, 32'h0, "RX read when empty");
    expect_reg(`SPI_REG_STATUS, 32'h2, "STATUS at end");

    $display("All tests passed");
    $finish;
  end

endmodule

//--- files.f
+incdir+source
source/spi_pkg.sv
source/spi_byte_fifo.sv
source/spi_sck_gen.sv
source/spi_shift_engine.sv
source/apb_spi_regs.sv
source/apb_spi_master.sv
testbench/spi_echo_slave.sv
testbench/tb_apb_spi_master.sv

//--- Makefile
TOP = tb_apb_spi_master

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)
	verilator --lint-only -f files.f --top-module apb_spi_master

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
